// File: Makefile
# Verilator flow for the packet-info read subsystem

VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
TB_TOP     ?= tb_piarb
RTL_TOP    ?= piarb_top
FILE_LIST  ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test failures found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+verilog
verilog/piarb_pkg.sv
verilog/ram_1r1w.sv
verilog/piarb_shared_memory.sv
verilog/piarb_desc_dispatch.sv
verilog/piarb_port_reader.sv
verilog/piarb_req_arbiter.sv
verilog/piarb_top.sv
tests/piarb_clk_gen.sv
tests/tb_piarb.sv

// File: tests/piarb_clk_gen.sv
// Testbench clock and reset source
// Free-running clock, reset held low for the first cycles

`timescale 1ns/1ps

module piarb_clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1; // Released on the edge after the last reset cycle
	end

endmodule

// File: tests/piarb_trace.txt
# W buf line data_hex : write one hop-info line
# D name src dst buf nlines inst gap : descriptor, gap in idle cycles, ? for random
W 0 0 1000
W 0 1 1001
W 0 2 1002
W 0 3 1003
W 1 0 2100
W 1 1 2101
W 2 0 3200
W 2 1 3201
W 2 2 3202
W 3 0 4300
W 5 0 5500
W 5 1 5501
W 5 2 5502
W 5 3 5503
D single_4line 0 1 0 4 0 ?
D two_lines_inst 1 2 1 2 1 ?
D four_ports_a 0 0 2 3 0 0
D four_ports_b 1 1 3 1 1 0
D four_ports_c 2 2 5 4 0 0
D four_ports_d 3 3 0 2 1 0
D same_src_back 3 2 1 2 0 ?
W 0 0 a0a0
W 0 1 a0a1
D rewrite_read 2 3 0 2 1 ?
D one_line_inst 1 0 3 1 1 ?

// File: tests/tb_piarb.sv
// Testbench for the packet-info read subsystem
// Replays write and descriptor records from the trace file, predicts
// every data ack and buffer release, and checks the descriptor handshake

`timescale 1ns/1ps
`include "piarb_settings.svh"

module tb_piarb;

	typedef struct packed {
		logic [7:0]           id;
		piarb_pkg::port_id_t  dst;
		piarb_pkg::port_id_t  src;
		piarb_pkg::buf_ptr_t  ptr;
		piarb_pkg::hop_word_t data;
		logic                 sop;
		logic                 eop;
		logic                 inst;
	} exp_line_t;

	logic clk;
	logic rst_n;
	logic write_data_valid;
	piarb_pkg::buf_ptr_t write_buf_ptr;
	piarb_pkg::line_idx_t write_line;
	piarb_pkg::hop_word_t write_data;
	logic desc_req;
	piarb_pkg::port_id_t desc_src_port;
	piarb_pkg::port_id_t desc_dst_port;
	piarb_pkg::buf_ptr_t desc_buf_ptr;
	piarb_pkg::line_cnt_t desc_nlines;
	logic desc_inst;
	logic desc_ack;
	logic rel_buf_valid;
	piarb_pkg::port_id_t rel_buf_port_id;
	piarb_pkg::buf_ptr_t rel_buf_ptr;
	logic data_ack_valid;
	piarb_pkg::port_id_t data_ack_port_id;
	logic data_ack_sop;
	logic data_ack_eop;
	logic data_ack_inst;
	piarb_pkg::hop_word_t data_ack_data;

	piarb_pkg::hop_word_t model [2**(`PIARB_BPTR_NBITS + `PIARB_LSB_NBITS)]; // Last write per line
	exp_line_t exp_q[$];
	string names[$];
	int test_errs[$];
	int rk[$], r1[$], r2[$], r3[$], r4[$], r5[$], rgap[$];
	string rname[$];
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int limit_cycles = 0;
	logic monitor_on = 1'b0;
	logic prev_req = 1'b0;
	logic prev_ack = 1'b0;
	logic prev_rel = 1'b0;
	piarb_pkg::port_id_t prev_rel_port;
	piarb_pkg::buf_ptr_t prev_rel_ptr;

	piarb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) i_clk_gen (.clk(clk), .rst_n(rst_n));

	piarb_top i_dut (
		.clk(clk), .rst_n(rst_n),
		.write_data_valid(write_data_valid), .write_buf_ptr(write_buf_ptr),
		.write_line(write_line), .write_data(write_data),
		.desc_req(desc_req), .desc_src_port(desc_src_port), .desc_dst_port(desc_dst_port),
		.desc_buf_ptr(desc_buf_ptr), .desc_nlines(desc_nlines), .desc_inst(desc_inst),
		.desc_ack(desc_ack),
		.rel_buf_valid(rel_buf_valid), .rel_buf_port_id(rel_buf_port_id),
		.rel_buf_ptr(rel_buf_ptr),
		.data_ack_valid(data_ack_valid), .data_ack_port_id(data_ack_port_id),
		.data_ack_sop(data_ack_sop), .data_ack_eop(data_ack_eop),
		.data_ack_inst(data_ack_inst), .data_ack_data(data_ack_data)
	);

	function automatic int add_test(input string name);
		names.push_back(name);
		test_errs.push_back(0);
		return names.size() - 1;
	endfunction

	function automatic int find_dst(input piarb_pkg::port_id_t dst);
		int idx;
		idx = -1;
		for (int i = exp_q.size() - 1; i >= 0; i--) begin
			if (exp_q[i].dst == dst) idx = i; // Oldest entry wins
		end
		return idx;
	endfunction

	task automatic store_record(input int kind, input int f1, input int f2, input int f3,
		input int f4, input int f5, input int gap, input string name);
		rk.push_back(kind);
		r1.push_back(f1);
		r2.push_back(f2);
		r3.push_back(f3);
		r4.push_back(f4);
		r5.push_back(f5);
		rgap.push_back(gap);
		rname.push_back(name);
	endtask

	task automatic note_error(input int id);
		errors++;
		test_errs[id]++;
	endtask

	task automatic report_fail(input int id, input string msg);
		$display("%s: %s", names[id], msg);
		note_error(id);
	endtask

	task automatic check_word(input int id, input string what,
		input piarb_pkg::hop_word_t exp_v, input piarb_pkg::hop_word_t act_v);
		if (act_v !== exp_v) begin
			$display("ERR %s %s: expected %h, actual %h", names[id], what, exp_v, act_v);
			note_error(id);
		end
	endtask

	task automatic check_port(input int id, input string what,
		input piarb_pkg::port_id_t exp_v, input piarb_pkg::port_id_t act_v);
		if (act_v !== exp_v) begin
			$display("ERR %s %s: expected %0d, actual %0d", names[id], what, exp_v, act_v);
			note_error(id);
		end
	endtask

	task automatic check_ptr(input int id, input string what,
		input piarb_pkg::buf_ptr_t exp_v, input piarb_pkg::buf_ptr_t act_v);
		if (act_v !== exp_v) begin
			$display("ERR %s %s: expected %h, actual %h", names[id], what, exp_v, act_v);
			note_error(id);
		end
	endtask

	task automatic check_flag(input int id, input string what, input logic exp_v,
		input logic act_v);
		if (act_v !== exp_v) begin
			$display("ERR %s %s: expected %b, actual %b", names[id], what, exp_v, act_v);
			note_error(id);
		end
	endtask

	task automatic finish_test(input int id);
		tests_run++;
		if (test_errs[id] == 0) begin
			$display("PASS %s", names[id]);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d errors", names[id], test_errs[id]);
		end
	endtask

	// Matches one returned line to the oldest open packet of its destination
	task automatic match_ack();
		int idx;
		int id;
		exp_line_t e;
		idx = find_dst(data_ack_port_id);
		if (idx < 0) begin
			report_fail(2, $sformatf("data ack on port %0d with no packet open",
				data_ack_port_id));
		end else begin
			e = exp_q[idx];
			exp_q.delete(idx);
			id = int'(e.id);
			check_word(id, "data", e.data, data_ack_data);
			check_flag(id, "sop", e.sop, data_ack_sop);
			check_flag(id, "eop", e.eop, data_ack_eop);
			check_flag(id, "inst", e.inst, data_ack_inst);
			if (e.eop) begin
				check_flag(id, "release before eop", 1'b1, prev_rel); // Release leads by a cycle
				check_port(id, "rel_buf_port_id", e.src, prev_rel_port);
				check_ptr(id, "rel_buf_ptr", e.ptr, prev_rel_ptr);
				finish_test(id);
			end
		end
	endtask

	task automatic drive_write(input int b, input int l, input int d);
		@(posedge clk);
		write_data_valid <= 1'b1;
		write_buf_ptr <= piarb_pkg::buf_ptr_t'(b);
		write_line <= piarb_pkg::line_idx_t'(l);
		write_data <= piarb_pkg::hop_word_t'(d);
		model[b * (1 << `PIARB_LSB_NBITS) + l] = piarb_pkg::hop_word_t'(d);
		@(posedge clk);
		write_data_valid <= 1'b0;
	endtask

	task automatic drive_desc(input int src, input int dst, input int ptr, input int n,
		input int inst);
		@(posedge clk);
		desc_src_port <= piarb_pkg::port_id_t'(src);
		desc_dst_port <= piarb_pkg::port_id_t'(dst);
		desc_buf_ptr <= piarb_pkg::buf_ptr_t'(ptr);
		desc_nlines <= piarb_pkg::line_cnt_t'(n);
		desc_inst <= inst[0];
		desc_req <= 1'b1;
		@(negedge clk);
		while (desc_ack !== 1'b1) @(negedge clk); // Late while the source reader is busy
		@(posedge clk);
		desc_req <= 1'b0;
		@(negedge clk);
		while (desc_ack !== 1'b0) @(negedge clk);
	endtask

	always @(negedge clk) begin
		if (monitor_on) begin
			if (rst_n !== 1'b1) begin
				check_flag(0, "rel_buf_valid", 1'b0, rel_buf_valid);
				check_flag(0, "data_ack_valid", 1'b0, data_ack_valid);
				check_flag(0, "desc_ack", 1'b0, desc_ack);
			end else begin
				if (desc_ack && !prev_ack && !desc_req)
					report_fail(1, "desc_ack rose while desc_req was low");
				if (!desc_ack && prev_ack && prev_req)
					report_fail(1, "desc_ack fell before desc_req dropped");
				if (prev_rel && !(data_ack_valid === 1'b1 && data_ack_eop === 1'b1))
					report_fail(2, "buffer release not followed by the end of a packet");
				if (data_ack_valid === 1'b1) match_ack();
			end
		end
		prev_req = desc_req;
		prev_ack = desc_ack;
		prev_rel = (rel_buf_valid === 1'b1) && (rst_n === 1'b1);
		prev_rel_port = rel_buf_port_id;
		prev_rel_ptr = rel_buf_ptr;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("Test failures found");
		$finish;
	end

	initial begin : main
		int fd;
		int cnt;
		int id;
		int n_lines;
		int a, b, c, d, e, gap;
		string line;
		string kind_s;
		string name_s;
		string gap_s;
		exp_line_t x;
		cnt = $urandom(77539);
		write_data_valid = 1'b0;
		write_buf_ptr = '0;
		write_line = '0;
		write_data = '0;
		desc_req = 1'b0;
		desc_src_port = '0;
		desc_dst_port = '0;
		desc_buf_ptr = '0;
		desc_nlines = '0;
		desc_inst = 1'b0;
		void'(add_test("reset"));
		void'(add_test("handshake"));
		void'(add_test("stray_events"));
		n_lines = 0;
		fd = $fopen("tests/piarb_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file tests/piarb_trace.txt");
			errors++;
		end
		while (fd != 0 && $fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) == "W") begin
				cnt = $sscanf(line, "%s %d %d %h", kind_s, a, b, c);
				store_record(0, a, b, c, 0, 0, 0, "");
			end else if (line.len() > 1 && line.getc(0) == "D") begin
				cnt = $sscanf(line, "%s %s %d %d %d %d %d %s", kind_s, name_s, a, b, c, d, e,
					gap_s);
				gap = -1; // A question mark leaves the gap to the random source
				if (gap_s != "?") cnt = $sscanf(gap_s, "%d", gap);
				store_record(1, a, b, c, d, e, gap, name_s);
				n_lines += d;
			end
		end
		if (fd != 0) $fclose(fd);
		limit_cycles = (rk.size() + n_lines) * 20 + 20;
		@(posedge clk);
		monitor_on = 1'b1;
		wait (rst_n === 1'b1);
		for (int r = 0; r < rk.size(); r++) begin
			if (rk[r] == 0) begin
				while (exp_q.size() != 0) @(negedge clk); // No write under a packet in flight
				drive_write(r1[r], r2[r], r3[r]);
			end else begin
				id = add_test(rname[r]);
				while (find_dst(piarb_pkg::port_id_t'(r2[r])) >= 0) @(negedge clk);
				for (int k = 0; k < r4[r]; k++) begin
					x.id = 8'(id);
					x.dst = piarb_pkg::port_id_t'(r2[r]);
					x.src = piarb_pkg::port_id_t'(r1[r]);
					x.ptr = piarb_pkg::buf_ptr_t'(r3[r]);
					x.data = model[r3[r] * (1 << `PIARB_LSB_NBITS) + k];
					x.sop = (k == 0);
					x.eop = (k == r4[r] - 1);
					x.inst = r5[r][0];
					exp_q.push_back(x);
				end
				drive_desc(r1[r], r2[r], r3[r], r4[r], r5[r]);
				gap = (rgap[r] < 0) ? int'($urandom % 4) : rgap[r];
				repeat (gap) @(posedge clk);
			end
		end
		while (exp_q.size() != 0) @(negedge clk);
		repeat (4) @(posedge clk);
		for (int i = 0; i < 3; i++) finish_test(i);
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: verilog/piarb_desc_dispatch.sv
// Descriptor dispatcher
// Four-phase req/ack receiver that hands each descriptor to the
// port reader of its source port once that reader is idle

`timescale 1ns/1ps
`include "piarb_settings.svh"

module piarb_desc_dispatch (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     desc_req,
	input  piarb_pkg::port_id_t      desc_src_port,
	input  logic [`PIARB_NPORTS-1:0] reader_busy,
	output logic                     desc_ack,
	output logic [`PIARB_NPORTS-1:0] load
);

	localparam logic [1:0] S_WAIT_REQ = 2'd0;
	localparam logic [1:0] S_ACK      = 2'd1; // Ack rises, load pulses
	localparam logic [1:0] S_WAIT_LOW = 2'd2; // Ack held until req drops

	logic [1:0] state;
	logic       accept;

	// Back-pressure is only a late ack while the target reader is busy
	assign accept = desc_req && !reader_busy[desc_src_port];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_WAIT_REQ;
			load <= '0;
		end else begin
			load <= '0;
			case (state)
				S_WAIT_REQ: begin
					if (accept) begin
						state <= S_ACK;
						load[desc_src_port] <= 1'b1;
					end
				end
				S_ACK, S_WAIT_LOW: begin
					if (!desc_req) begin
						state <= S_WAIT_REQ;
					end else begin
						state <= S_WAIT_LOW;
					end
				end
				default: state <= S_WAIT_REQ;
			endcase
		end
	end

	assign desc_ack = (state != S_WAIT_REQ);

	// At most one reader is loaded per descriptor
	a_load_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(load));

endmodule

// File: verilog/piarb_pkg.sv
// Packet-info arbiter types
// Field types for descriptors, line requests and stored hop-info lines,
// all sized from the settings header

`include "piarb_settings.svh"

package piarb_pkg;

	// Source or destination processing unit
	typedef logic [`PIARB_ID_NBITS-1:0] port_id_t;

	// Buffer in the shared store
	typedef logic [`PIARB_BPTR_NBITS-1:0] buf_ptr_t;

	// Line inside one buffer
	typedef logic [`PIARB_LSB_NBITS-1:0] line_idx_t;

	// Lines in a packet, 1 to 4, so one bit wider than the index
	typedef logic [`PIARB_LSB_NBITS:0] line_cnt_t;

	// Stored hop-info word, never decoded inside the subsystem
	typedef logic [`PIARB_DATA_NBITS-1:0] hop_word_t;

endpackage

// File: verilog/piarb_port_reader.sv
// Per-port packet reader
// Latches one descriptor and walks its lines from line 0,
// requesting one line at a time and stepping on each grant

`timescale 1ns/1ps

module piarb_port_reader (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load,
	input  piarb_pkg::port_id_t  desc_dst_port,
	input  piarb_pkg::buf_ptr_t  desc_buf_ptr,
	input  piarb_pkg::line_cnt_t desc_nlines,
	input  logic                 desc_inst,
	input  logic                 line_grant,
	output logic                 busy,
	output logic                 line_req,
	output piarb_pkg::port_id_t  line_dst,
	output piarb_pkg::buf_ptr_t  line_buf_ptr,
	output piarb_pkg::line_idx_t line_idx,
	output logic                 line_sop,
	output logic                 line_eop,
	output logic                 line_inst
);

	logic                 active;
	piarb_pkg::line_cnt_t remain; // Lines still to be granted
	logic                 last;

	assign last = (remain == piarb_pkg::line_cnt_t'(1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else if (load) begin
			active <= 1'b1;
		end else if (line_grant && last) begin
			active <= 1'b0; // Last line taken by the arbiter
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			line_dst <= desc_dst_port;
			line_buf_ptr <= desc_buf_ptr;
			line_inst <= desc_inst;
			line_idx <= '0;
			remain <= desc_nlines;
		end else if (line_grant) begin
			line_idx <= line_idx + piarb_pkg::line_idx_t'(1);
			remain <= remain - piarb_pkg::line_cnt_t'(1);
		end
	end

	assign busy = active;
	assign line_req = active;
	assign line_sop = (line_idx == '0);
	assign line_eop = last;

	// Dispatcher waits for idle before loading
	a_no_load_busy: assert property (@(posedge clk) disable iff (!rst_n)
		load |-> !active);

endmodule

// File: verilog/piarb_req_arbiter.sv
// Line request arbiter
// Round-robin choice among the port readers, one line per cycle,
// forwarded to the shared memory as a registered data request

`timescale 1ns/1ps
`include "piarb_settings.svh"

module piarb_req_arbiter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`PIARB_NPORTS-1:0] line_req,
	input  piarb_pkg::port_id_t      line_dst [`PIARB_NPORTS],
	input  piarb_pkg::buf_ptr_t      line_buf_ptr [`PIARB_NPORTS],
	input  piarb_pkg::line_idx_t     line_idx [`PIARB_NPORTS],
	input  logic [`PIARB_NPORTS-1:0] line_sop,
	input  logic [`PIARB_NPORTS-1:0] line_eop,
	input  logic [`PIARB_NPORTS-1:0] line_inst,
	output logic [`PIARB_NPORTS-1:0] line_grant,
	output logic                     data_req,
	output piarb_pkg::port_id_t      data_req_src_port_id,
	output piarb_pkg::port_id_t      data_req_dst_port_id,
	output logic                     data_req_sop,
	output logic                     data_req_eop,
	output piarb_pkg::buf_ptr_t      data_req_buf_ptr,
	output piarb_pkg::line_idx_t     data_req_buf_ptr_lsb,
	output logic                     data_req_inst
);

	piarb_pkg::port_id_t rr_ptr; // Highest priority this cycle
	piarb_pkg::port_id_t winner;
	logic                any_req;

	assign any_req = |line_req;

	always_comb begin
		int   slot;
		logic found;
		found = 1'b0;
		line_grant = '0;
		winner = rr_ptr;
		for (int k = 0; k < `PIARB_NPORTS; k++) begin
			slot = (int'(rr_ptr) + k) % `PIARB_NPORTS;
			if (!found && line_req[slot]) begin
				found = 1'b1;
				line_grant[slot] = 1'b1;
				winner = piarb_pkg::port_id_t'(slot);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_req <= 1'b0;
			rr_ptr <= '0;
		end else begin
			data_req <= any_req;
			if (any_req) begin
				// Next search starts just past the winner
				rr_ptr <= (winner == piarb_pkg::port_id_t'(`PIARB_NPORTS - 1)) ?
					'0 : winner + piarb_pkg::port_id_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		data_req_src_port_id <= winner;
		data_req_dst_port_id <= line_dst[winner];
		data_req_buf_ptr <= line_buf_ptr[winner];
		data_req_buf_ptr_lsb <= line_idx[winner];
		data_req_sop <= line_sop[winner];
		data_req_eop <= line_eop[winner];
		data_req_inst <= line_inst[winner];
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		any_req |-> $onehot(line_grant) && ((line_grant & ~line_req) == '0));

endmodule

// File: verilog/piarb_settings.svh
// Packet-info arbiter build settings
// Port count and field widths shared by the package and the RTL

`ifndef PIARB_SETTINGS_SVH
`define PIARB_SETTINGS_SVH

// Number of processing-unit ports, one port reader each
`define PIARB_NPORTS 4

// Port id, wide enough to name every port
`define PIARB_ID_NBITS 2

// Buffer pointer into the shared line store
`define PIARB_BPTR_NBITS 4

// Line within a buffer, four lines per buffer
`define PIARB_LSB_NBITS 2

// One hop-info line
`define PIARB_DATA_NBITS 16

`endif

// File: verilog/piarb_shared_memory.sv
// Shared hop-info line store
// Registers writes into the RAM, pipelines read requests two stages,
// returns each line tagged for its destination and flags buffer release
// on the end of a packet or on the last line of a buffer

`timescale 1ns/1ps
`include "piarb_settings.svh"

module piarb_shared_memory (
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic                 write_data_valid,
	input  piarb_pkg::buf_ptr_t  write_buf_ptr,
	input  piarb_pkg::line_idx_t write_buf_ptr_lsb,
	input  piarb_pkg::hop_word_t write_data,

	input  logic                 data_req,
	input  piarb_pkg::port_id_t  data_req_src_port_id,
	input  piarb_pkg::port_id_t  data_req_dst_port_id,
	input  logic                 data_req_sop,
	input  logic                 data_req_eop,
	input  piarb_pkg::buf_ptr_t  data_req_buf_ptr,
	input  piarb_pkg::line_idx_t data_req_buf_ptr_lsb,
	input  logic                 data_req_inst,

	output logic                 rel_buf_valid,
	output piarb_pkg::port_id_t  rel_buf_port_id,
	output piarb_pkg::buf_ptr_t  rel_buf_ptr,

	output logic                 data_ack_valid,
	output piarb_pkg::port_id_t  data_ack_port_id,
	output logic                 data_ack_sop,
	output logic                 data_ack_eop,
	output logic                 data_ack_inst,
	output piarb_pkg::hop_word_t data_ack_data
);

	// Stage 1 of the request pipeline addresses the RAM
	logic                 req_d1;
	piarb_pkg::port_id_t  src_d1;
	piarb_pkg::port_id_t  dst_d1;
	logic                 sop_d1;
	logic                 eop_d1;
	logic                 inst_d1;
	piarb_pkg::buf_ptr_t  ptr_d1;
	piarb_pkg::line_idx_t lsb_d1;

	// Stage 2 waits for the registered read
	logic                 req_d2;
	piarb_pkg::port_id_t  dst_d2;
	logic                 sop_d2;
	logic                 eop_d2;
	logic                 inst_d2;

	logic                 wr_d1;
	piarb_pkg::buf_ptr_t  wr_ptr_d1;
	piarb_pkg::line_idx_t wr_lsb_d1;
	piarb_pkg::hop_word_t wr_data_d1;
	piarb_pkg::hop_word_t ram_dout;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_d1 <= 1'b0;
			req_d2 <= 1'b0;
			wr_d1 <= 1'b0;
			rel_buf_valid <= 1'b0;
			data_ack_valid <= 1'b0;
		end else begin
			req_d1 <= data_req;
			req_d2 <= req_d1;
			wr_d1 <= write_data_valid;
			rel_buf_valid <= req_d1 & (eop_d1 | (&lsb_d1)); // Packet end or buffer full
			data_ack_valid <= req_d2;
		end
	end

	always_ff @(posedge clk) begin
		src_d1 <= data_req_src_port_id;
		dst_d1 <= data_req_dst_port_id;
		sop_d1 <= data_req_sop;
		eop_d1 <= data_req_eop;
		inst_d1 <= data_req_inst;
		ptr_d1 <= data_req_buf_ptr;
		lsb_d1 <= data_req_buf_ptr_lsb;
		dst_d2 <= dst_d1;
		sop_d2 <= sop_d1;
		eop_d2 <= eop_d1;
		inst_d2 <= inst_d1;
		wr_ptr_d1 <= write_buf_ptr;
		wr_lsb_d1 <= write_buf_ptr_lsb;
		wr_data_d1 <= write_data;
		rel_buf_port_id <= src_d1; // Release goes back to the reading port
		rel_buf_ptr <= ptr_d1;
		data_ack_port_id <= dst_d2;
		data_ack_sop <= sop_d2;
		data_ack_eop <= eop_d2;
		data_ack_inst <= inst_d2;
		data_ack_data <= ram_dout;
	end

	ram_1r1w #(
		.DATA_NBITS(`PIARB_DATA_NBITS),
		.ADDR_NBITS(`PIARB_BPTR_NBITS + `PIARB_LSB_NBITS)
	) i_ram (
		.clk(clk),
		.wr(wr_d1),
		.waddr({wr_ptr_d1, wr_lsb_d1}),
		.raddr({ptr_d1, lsb_d1}),
		.din(wr_data_d1),
		.dout(ram_dout)
	);

endmodule

// File: verilog/piarb_top.sv
// Packet-info read subsystem
// Descriptor dispatcher, one reader per processing unit, round-robin
// arbiter and the shared line store

`timescale 1ns/1ps
`include "piarb_settings.svh"

module piarb_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 write_data_valid,
	input  piarb_pkg::buf_ptr_t  write_buf_ptr,
	input  piarb_pkg::line_idx_t write_line,
	input  piarb_pkg::hop_word_t write_data,
	input  logic                 desc_req,
	input  piarb_pkg::port_id_t  desc_src_port,
	input  piarb_pkg::port_id_t  desc_dst_port,
	input  piarb_pkg::buf_ptr_t  desc_buf_ptr,
	input  piarb_pkg::line_cnt_t desc_nlines,
	input  logic                 desc_inst,
	output logic                 desc_ack,
	output logic                 rel_buf_valid,
	output piarb_pkg::port_id_t  rel_buf_port_id,
	output piarb_pkg::buf_ptr_t  rel_buf_ptr,
	output logic                 data_ack_valid,
	output piarb_pkg::port_id_t  data_ack_port_id,
	output logic                 data_ack_sop,
	output logic                 data_ack_eop,
	output logic                 data_ack_inst,
	output piarb_pkg::hop_word_t data_ack_data
);

	logic [`PIARB_NPORTS-1:0] reader_busy;
	logic [`PIARB_NPORTS-1:0] load;
	logic [`PIARB_NPORTS-1:0] line_req;
	logic [`PIARB_NPORTS-1:0] line_grant;
	logic [`PIARB_NPORTS-1:0] line_sop;
	logic [`PIARB_NPORTS-1:0] line_eop;
	logic [`PIARB_NPORTS-1:0] line_inst;
	piarb_pkg::port_id_t      line_dst [`PIARB_NPORTS];
	piarb_pkg::buf_ptr_t      line_buf_ptr [`PIARB_NPORTS];
	piarb_pkg::line_idx_t     line_idx [`PIARB_NPORTS];

	logic                 data_req;
	piarb_pkg::port_id_t  data_req_src_port_id;
	piarb_pkg::port_id_t  data_req_dst_port_id;
	logic                 data_req_sop;
	logic                 data_req_eop;
	piarb_pkg::buf_ptr_t  data_req_buf_ptr;
	piarb_pkg::line_idx_t data_req_buf_ptr_lsb;
	logic                 data_req_inst;

	piarb_desc_dispatch i_dispatch (
		.clk(clk),
		.rst_n(rst_n),
		.desc_req(desc_req),
		.desc_src_port(desc_src_port),
		.reader_busy(reader_busy),
		.desc_ack(desc_ack),
		.load(load)
	);

	// Descriptor fields fan out to all readers, only the loaded one keeps them
	for (genvar i = 0; i < `PIARB_NPORTS; i++) begin : g_reader
		piarb_port_reader i_reader (
			.clk(clk),
			.rst_n(rst_n),
			.load(load[i]),
			.desc_dst_port(desc_dst_port),
			.desc_buf_ptr(desc_buf_ptr),
			.desc_nlines(desc_nlines),
			.desc_inst(desc_inst),
			.line_grant(line_grant[i]),
			.busy(reader_busy[i]),
			.line_req(line_req[i]),
			.line_dst(line_dst[i]),
			.line_buf_ptr(line_buf_ptr[i]),
			.line_idx(line_idx[i]),
			.line_sop(line_sop[i]),
			.line_eop(line_eop[i]),
			.line_inst(line_inst[i])
		);
	end

	piarb_req_arbiter i_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.line_req(line_req),
		.line_dst(line_dst),
		.line_buf_ptr(line_buf_ptr),
		.line_idx(line_idx),
		.line_sop(line_sop),
		.line_eop(line_eop),
		.line_inst(line_inst),
		.line_grant(line_grant),
		.data_req(data_req),
		.data_req_src_port_id(data_req_src_port_id),
		.data_req_dst_port_id(data_req_dst_port_id),
		.data_req_sop(data_req_sop),
		.data_req_eop(data_req_eop),
		.data_req_buf_ptr(data_req_buf_ptr),
		.data_req_buf_ptr_lsb(data_req_buf_ptr_lsb),
		.data_req_inst(data_req_inst)
	);

	piarb_shared_memory i_memory (
		.clk(clk),
		.rst_n(rst_n),
		.write_data_valid(write_data_valid),
		.write_buf_ptr(write_buf_ptr),
		.write_buf_ptr_lsb(write_line),
		.write_data(write_data),
		.data_req(data_req),
		.data_req_src_port_id(data_req_src_port_id),
		.data_req_dst_port_id(data_req_dst_port_id),
		.data_req_sop(data_req_sop),
		.data_req_eop(data_req_eop),
		.data_req_buf_ptr(data_req_buf_ptr),
		.data_req_buf_ptr_lsb(data_req_buf_ptr_lsb),
		.data_req_inst(data_req_inst),
		.rel_buf_valid(rel_buf_valid),
		.rel_buf_port_id(rel_buf_port_id),
		.rel_buf_ptr(rel_buf_ptr),
		.data_ack_valid(data_ack_valid),
		.data_ack_port_id(data_ack_port_id),
		.data_ack_sop(data_ack_sop),
		.data_ack_eop(data_ack_eop),
		.data_ack_inst(data_ack_inst),
		.data_ack_data(data_ack_data)
	);

endmodule

// File: verilog/ram_1r1w.sv
// Simple dual-port RAM
// One write port and one read port on the same clock,
// read data is registered and shows one cycle after raddr

`timescale 1ns/1ps

module ram_1r1w #(
	parameter int DATA_NBITS = 16,
	parameter int ADDR_NBITS = 6
) (
	input  logic                  clk,
	input  logic                  wr,
	input  logic [ADDR_NBITS-1:0] waddr,
	input  logic [ADDR_NBITS-1:0] raddr,
	input  logic [DATA_NBITS-1:0] din,
	output logic [DATA_NBITS-1:0] dout
);

	logic [DATA_NBITS-1:0] mem [2**ADDR_NBITS];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr]; // Old data on a same-cycle collision
	end

endmodule
